/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // Field widths of the base integer ISA
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;
    localparam int SHAMT_W   = 5;

    typedef logic [XLEN-1:0]      rv_word_t;
    typedef logic [REG_IDX_W-1:0] rv_reg_idx_t;
    typedef logic [FUNCT3_W-1:0]  rv_funct3_t;
    typedef logic [FUNCT7_W-1:0]  rv_funct7_t;

    // Major opcodes handled by the integer core
    typedef enum logic [OPCODE_W-1:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        op_lui = 7'b0110111
    } rv_opcode_e;

    // funct3 codes shared by OP and OP-IMM
    localparam rv_funct3_t F3_ADD_SUB = 3'b000;
    localparam rv_funct3_t F3_SLL     = 3'b001;
    localparam rv_funct3_t F3_SLT     = 3'b010;
    localparam rv_funct3_t F3_SLTU    = 3'b011;
    localparam rv_funct3_t F3_XOR     = 3'b100;
    localparam rv_funct3_t F3_SRL_SRA = 3'b101;
    localparam rv_funct3_t F3_OR      = 3'b110;
    localparam rv_funct3_t F3_AND     = 3'b111;

    // funct7 values
    localparam rv_funct7_t FUNCT7_BASE = 7'b0000000;
    // Selects sub and sra
    localparam rv_funct7_t FUNCT7_ALT  = 7'b0100000;

endpackage

/* rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    // ALU operations, one per RV32I integer function
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Operand A source
    // Zero feeds LUI so that the ALU adds the U immediate to nothing
    typedef enum logic {
        opa_rs1  = 1'b0,
        opa_zero = 1'b1
    } opa_sel_e;

    // Operand B source
    typedef enum logic {
        opb_rs2 = 1'b0,
        opb_imm = 1'b1
    } opb_sel_e;

endpackage

/* rv_alu.sv */
module rv_alu
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  alu_op_e  op_i,
    input  rv_word_t a_i,
    input  rv_word_t b_i,
    output rv_word_t y_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // Shifts only look at the low bits of operand B
    assign shamt = b_i[SHAMT_W-1:0];

    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            alu_add: begin
                y_o = a_i + b_i;
            end
            alu_sub: begin
                y_o = a_i - b_i;
            end
            alu_sll: begin
                y_o = a_i << shamt;
            end
            alu_slt: begin
                y_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                y_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                y_o = a_i ^ b_i;
            end
            alu_srl: begin
                y_o = a_i >> shamt;
            end
            alu_sra: begin
                // Arithmetic shift keeps the sign of operand A
                y_o = rv_word_t'($signed(a_i) >>> shamt);
            end
            alu_or: begin
                y_o = a_i | b_i;
            end
            alu_and: begin
                y_o = a_i & b_i;
            end
            default: begin
                y_o = '0;
            end
        endcase
    end

endmodule

/* rv_decoder.sv */
module rv_decoder
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic        valid_i,
    input  rv_word_t    inst_i,
    output logic        valid_o,
    output alu_op_e     alu_op_o,
    output opa_sel_e    opa_sel_o,
    output opb_sel_e    opb_sel_o,
    output rv_reg_idx_t rs1_o,
    output rv_reg_idx_t rs2_o,
    output rv_reg_idx_t rd_o,
    output rv_word_t    imm_o
);

    rv_opcode_e opcode;
    rv_funct3_t funct3;
    rv_funct7_t funct7;
    logic       alt;
    logic       is_shift;
    logic       shift_ok;
    logic       kept;

    // Maps funct3 plus the alternate bit onto an ALU operation
    function automatic alu_op_e map_funct3(rv_funct3_t f3, logic sel_alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = sel_alt ? alu_sub : alu_add;
            F3_SLL:     op = alu_sll;
            F3_SLT:     op = alu_slt;
            F3_SLTU:    op = alu_sltu;
            F3_XOR:     op = alu_xor;
            F3_SRL_SRA: op = sel_alt ? alu_sra : alu_srl;
            F3_OR:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = rv_opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign alt    = (funct7 == FUNCT7_ALT);

    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);
    // Only srl/sra may carry the alternate funct7
    assign shift_ok = (funct7 == FUNCT7_BASE) || (alt && funct3 == F3_SRL_SRA);

    always_comb begin
        kept      = 1'b0;
        alu_op_o  = alu_add;
        opa_sel_o = opa_rs1;
        opb_sel_o = opb_rs2;
        rs1_o     = inst_i[19:15];
        rs2_o     = inst_i[24:20];
        rd_o      = inst_i[11:7];
        imm_o     = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};

        case (opcode)
            op_reg: begin
                alu_op_o = map_funct3(funct3, alt);
                kept     = (funct7 == FUNCT7_BASE) ||
                           (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            op_imm: begin
                opb_sel_o = opb_imm;
                rs2_o     = '0;
                // addi has no subtract form, bit 30 belongs to the immediate
                alu_op_o  = map_funct3(funct3, alt && funct3 == F3_SRL_SRA);
                if (is_shift) begin
                    imm_o = {{(XLEN-SHAMT_W){1'b0}}, inst_i[20 +: SHAMT_W]};
                    kept  = shift_ok;
                end else begin
                    kept = 1'b1;
                end
            end
            op_lui: begin
                opa_sel_o = opa_zero;
                opb_sel_o = opb_imm;
                rs1_o     = '0;
                rs2_o     = '0;
                imm_o     = {inst_i[31:12], 12'h000};
                kept      = 1'b1;
            end
            default: ;
        endcase

        // Writes to x0 and unknown encodings become bubbles
        valid_o = valid_i && kept && (rd_o != '0);
    end

endmodule

/* rv_regfile.sv */
module rv_regfile
    import rv_isa_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        we_i,
    input  rv_reg_idx_t waddr_i,
    input  rv_word_t    wdata_i,
    input  rv_reg_idx_t raddr_a_i,
    input  rv_reg_idx_t raddr_b_i,
    output rv_word_t    rdata_a_o,
    output rv_word_t    rdata_b_o
);

    localparam int IDX_W = $clog2(NUM_REGS);

    rv_word_t regs [NUM_REGS];

    // RV32E style builds leave the upper indices unimplemented
    function automatic logic in_range(rv_reg_idx_t idx);
        return int'(idx) < NUM_REGS;
    endfunction

    // x0 reads zero, the write in flight wins over the stored value
    function automatic rv_word_t read_port(rv_reg_idx_t addr);
        rv_word_t data;
        if (addr == '0 || !in_range(addr)) begin
            data = '0;
        end else if (we_i && addr == waddr_i) begin
            data = wdata_i;
        end else begin
            data = regs[addr[IDX_W-1:0]];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0 && in_range(waddr_i)) begin
            regs[waddr_i[IDX_W-1:0]] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

    // Decode drops rd == x0, so a write to x0 never reaches this port
    assert property (@(posedge clk) disable iff (rst_i) we_i |-> (waddr_i != '0));

endmodule

/* rv_execute.sv */
module rv_execute
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        valid_i,
    input  alu_op_e     alu_op_i,
    input  opa_sel_e    opa_sel_i,
    input  opb_sel_e    opb_sel_i,
    input  rv_reg_idx_t rs1_i,
    input  rv_reg_idx_t rs2_i,
    input  rv_reg_idx_t rd_i,
    input  rv_word_t    rs1_data_i,
    input  rv_word_t    rs2_data_i,
    input  rv_word_t    imm_i,
    output logic        wb_valid_o,
    output rv_reg_idx_t wb_rd_o,
    output rv_word_t    wb_data_o
);

    logic     wb_live;
    logic     fwd_a;
    logic     fwd_b;
    rv_word_t rs1_val;
    rv_word_t rs2_val;
    rv_word_t opa;
    rv_word_t opb;
    rv_word_t alu_y;

    // Result of the previous instruction, not yet in the regfile
    assign wb_live = wb_valid_o && (wb_rd_o != '0);
    assign fwd_a   = wb_live && (wb_rd_o == rs1_i);
    assign fwd_b   = wb_live && (wb_rd_o == rs2_i);

    assign rs1_val = fwd_a ? wb_data_o : rs1_data_i;
    assign rs2_val = fwd_b ? wb_data_o : rs2_data_i;

    // Operand muxes
    assign opa = (opa_sel_i == opa_zero) ? '0 : rs1_val;
    assign opb = (opb_sel_i == opb_imm) ? imm_i : rs2_val;

    rv_alu alu (
        .op_i (alu_op_i),
        .a_i  (opa),
        .b_i  (opb),
        .y_o  (alu_y)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
        end
    end

    // Writeback payload
    always_ff @(posedge clk) begin
        wb_rd_o   <= rd_i;
        wb_data_o <= alu_y;
    end

    // Decoder filters rd == x0 two stages earlier
    assert property (@(posedge clk) disable iff (rst_i) wb_valid_o |-> (wb_rd_o != '0));

endmodule

/* rv_int_core.sv */
module rv_int_core
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        inst_valid_i,
    input  rv_word_t    inst_i,
    output logic        wb_valid_o,
    output rv_reg_idx_t wb_rd_o,
    output rv_word_t    wb_data_o
);

    // Fetch register
    logic        f_valid;
    rv_word_t    f_inst;

    // Decoder and regfile outputs
    logic        dec_valid;
    logic        dec_ok;
    alu_op_e     dec_alu_op;
    opa_sel_e    dec_opa_sel;
    opb_sel_e    dec_opb_sel;
    rv_reg_idx_t dec_rs1;
    rv_reg_idx_t dec_rs2;
    rv_reg_idx_t dec_rd;
    rv_word_t    dec_imm;
    rv_word_t    rf_rdata_a;
    rv_word_t    rf_rdata_b;

    // Decode register
    logic        d_valid;
    alu_op_e     d_alu_op;
    opa_sel_e    d_opa_sel;
    opb_sel_e    d_opb_sel;
    rv_reg_idx_t d_rs1;
    rv_reg_idx_t d_rs2;
    rv_reg_idx_t d_rd;
    rv_word_t    d_rs1_data;
    rv_word_t    d_rs2_data;
    rv_word_t    d_imm;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        f_inst <= inst_i;
    end

    rv_decoder decoder (
        .valid_i   (f_valid),
        .inst_i    (f_inst),
        .valid_o   (dec_valid),
        .alu_op_o  (dec_alu_op),
        .opa_sel_o (dec_opa_sel),
        .opb_sel_o (dec_opb_sel),
        .rs1_o     (dec_rs1),
        .rs2_o     (dec_rs2),
        .rd_o      (dec_rd),
        .imm_o     (dec_imm)
    );

    // A destination beyond the implemented registers is a bubble,
    // so forwarding never supplies a value the regfile would not hold
    assign dec_ok = dec_valid && (int'(dec_rd) < NUM_REGS);

    rv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) regfile (
        .clk       (clk),
        .rst_i     (rst_i),
        .we_i      (wb_valid_o),
        .waddr_i   (wb_rd_o),
        .wdata_i   (wb_data_o),
        .raddr_a_i (dec_rs1),
        .raddr_b_i (dec_rs2),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= dec_ok;
        end
    end

    always_ff @(posedge clk) begin
        d_alu_op   <= dec_alu_op;
        d_opa_sel  <= dec_opa_sel;
        d_opb_sel  <= dec_opb_sel;
        d_rs1      <= dec_rs1;
        d_rs2      <= dec_rs2;
        d_rd       <= dec_rd;
        d_rs1_data <= rf_rdata_a;
        d_rs2_data <= rf_rdata_b;
        d_imm      <= dec_imm;
    end

    // Writeback register feeds both the outputs and the regfile port
    rv_execute execute (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (d_valid),
        .alu_op_i   (d_alu_op),
        .opa_sel_i  (d_opa_sel),
        .opb_sel_i  (d_opb_sel),
        .rs1_i      (d_rs1),
        .rs2_i      (d_rs2),
        .rd_i       (d_rd),
        .rs1_data_i (d_rs1_data),
        .rs2_data_i (d_rs2_data),
        .imm_i      (d_imm),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

/* tb_int_core.sv */
module tb_int_core
    import rv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef rv_word_t reg_model_t [32];

    localparam int GAP         = 4;
    localparam int DRAIN_LIMIT = 50;
    localparam int LATENCY     = 3;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        inst_valid_i;
    rv_word_t    inst_i;
    logic        wb_valid_o;
    rv_reg_idx_t wb_rd_o;
    rv_word_t    wb_data_o;

    reg_model_t  model;
    rv_reg_idx_t exp_rd_q [$];
    rv_word_t    exp_data_q [$];
    int          exp_cycle_q [$];
    int          cycle = 0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          mark = 0;

    rv_int_core #(
        .NUM_REGS (32)
    ) DUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic rv_word_t r_type(rv_funct3_t f3, logic alt, int rd, int rs1, int rs2);
        rv_funct7_t f7;
        f7 = alt ? FUNCT7_ALT : FUNCT7_BASE;
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic rv_word_t i_type(rv_funct3_t f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op_imm};
    endfunction

    function automatic rv_word_t u_type(int rd, int imm20);
        return {imm20[19:0], rd[4:0], op_lui};
    endfunction

    // Integer result as RV32I defines it
    function automatic rv_word_t int_op(rv_funct3_t f3, logic alt, rv_word_t a, rv_word_t b);
        rv_word_t y;
        case (f3)
            F3_ADD_SUB: y = alt ? a - b : a + b;
            F3_SLL:     y = a << b[4:0];
            F3_SLT:     y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    y = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     y = a ^ b;
            F3_SRL_SRA: y = alt ? rv_word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      y = a | b;
            default:    y = a & b;
        endcase
        return y;
    endfunction

    // Returns 1 when a writeback is due, and updates the register model
    function automatic logic ref_exec(inout reg_model_t regs, input rv_word_t inst,
                                      output rv_reg_idx_t rd, output rv_word_t value);
        rv_funct3_t f3;
        rv_funct7_t f7;
        rv_word_t   a;
        rv_word_t   b;
        logic       ok;
        f3    = inst[14:12];
        f7    = inst[31:25];
        rd    = inst[11:7];
        a     = regs[inst[19:15]];
        b     = regs[inst[24:20]];
        ok    = 1'b0;
        value = '0;
        if (inst[6:0] == op_reg) begin
            ok = (f7 == FUNCT7_BASE) ||
                 (f7 == FUNCT7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
            value = int_op(f3, f7 == FUNCT7_ALT, a, b);
        end else if (inst[6:0] == op_imm) begin
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                // Shift amount sits in the rs2 field
                ok = (f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT && f3 == F3_SRL_SRA);
                value = int_op(f3, f7 == FUNCT7_ALT, a, {27'b0, inst[24:20]});
            end else begin
                ok = 1'b1;
                value = int_op(f3, 1'b0, a, {{20{inst[31]}}, inst[31:20]});
            end
        end else if (inst[6:0] == op_lui) begin
            ok = 1'b1;
            value = {inst[31:12], 12'h000};
        end
        if (ok && rd != '0) begin
            regs[rd] = value;
        end
        return ok && (rd != '0);
    endfunction

    // Mostly low registers so that dependencies are frequent
    function automatic int pick_reg();
        if ($urandom_range(0, 3) == 0) begin
            return int'($urandom_range(0, 31));
        end
        return int'($urandom_range(0, 7));
    endfunction

    function automatic rv_word_t rand_inst();
        int         kind;
        rv_funct3_t f3;
        logic       alt;
        int         rd;
        int         rs1;
        int         rs2;
        kind = int'($urandom_range(0, 19));
        f3   = rv_funct3_t'($urandom_range(0, 7));
        alt  = 1'($urandom_range(0, 1));
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        if (kind < 9) begin
            alt = alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA);
            return r_type(f3, alt, rd, rs1, rs2);
        end
        if (kind < 18) begin
            if (f3 == F3_SLL) begin
                return i_type(f3, rd, rs1, rs2);
            end
            if (f3 == F3_SRL_SRA) begin
                return i_type(f3, rd, rs1, (alt ? 'h400 : 0) + rs2);
            end
            return i_type(f3, rd, rs1, int'($urandom_range(0, 4095)));
        end
        return u_type(rd, int'($urandom_range(0, 'hFFFFF)));
    endfunction

    // Drive one strobe, then gap idle cycles
    task automatic issue(input rv_word_t inst, input int gap);
        rv_reg_idx_t rd;
        rv_word_t    value;
        @(negedge clk);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        if (ref_exec(model, inst, rd, value)) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(value);
            exp_cycle_q.push_back(cycle);
        end
        repeat (gap) begin
            @(negedge clk);
            inst_valid_i = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        @(negedge clk);
        inst_valid_i = 1'b0;
        while (exp_rd_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        checks++;
        assert (exp_rd_q.size() == 0) else begin
            errors++;
            $display("timeout in test %s: %0d expected writebacks never arrived",
                     name, exp_rd_q.size());
            exp_rd_q.delete();
            exp_data_q.delete();
            exp_cycle_q.delete();
        end
        // Extra writebacks would show up within the pipeline depth
        repeat (LATENCY + 1) @(posedge clk);
        tests++;
        if (errors == mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    task automatic check_after_reset();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checks++;
            assert (!wb_valid_o) else begin
                errors++;
                $display("wb_valid_o went high at %0t with no instruction issued", $time);
            end
        end
        // Each register is sourced once and must read zero
        for (int r = 1; r < 32; r++) begin
            issue(r_type(F3_ADD_SUB, 1'b0, r, r, 32 - r), 0);
        end
        finish_test("reset state");
    endtask

    task automatic check_each_op();
        issue(u_type(1, 'h80001), GAP);
        issue(i_type(F3_ADD_SUB, 1, 1, 'h234), GAP);
        issue(i_type(F3_ADD_SUB, 2, 0, 13), GAP);
        issue(r_type(F3_ADD_SUB, 1'b0, 3, 1, 2), GAP);
        issue(r_type(F3_ADD_SUB, 1'b1, 4, 1, 2), GAP);
        issue(r_type(F3_SLL, 1'b0, 5, 1, 2), GAP);
        issue(r_type(F3_SLT, 1'b0, 6, 1, 2), GAP);
        issue(r_type(F3_SLTU, 1'b0, 7, 1, 2), GAP);
        issue(r_type(F3_XOR, 1'b0, 8, 1, 2), GAP);
        issue(r_type(F3_SRL_SRA, 1'b0, 9, 1, 2), GAP);
        issue(r_type(F3_SRL_SRA, 1'b1, 10, 1, 2), GAP);
        issue(r_type(F3_OR, 1'b0, 11, 1, 2), GAP);
        issue(r_type(F3_AND, 1'b0, 12, 1, 2), GAP);
        issue(i_type(F3_ADD_SUB, 13, 1, -7), GAP);
        issue(i_type(F3_SLT, 14, 1, 5), GAP);
        issue(i_type(F3_SLTU, 15, 2, -1), GAP);
        issue(i_type(F3_XOR, 16, 2, 'h555), GAP);
        issue(i_type(F3_OR, 17, 1, -256), GAP);
        issue(i_type(F3_AND, 18, 1, 'h0F0), GAP);
        issue(i_type(F3_SLL, 19, 1, 4), GAP);
        issue(i_type(F3_SRL_SRA, 20, 1, 8), GAP);
        issue(i_type(F3_SRL_SRA, 21, 1, 'h400 + 8), GAP);
        issue(u_type(22, 'hABCDE), GAP);
        finish_test("single operations");
    endtask

    task automatic check_forwarding();
        issue(i_type(F3_ADD_SUB, 5, 0, 7), 0);
        issue(i_type(F3_ADD_SUB, 5, 5, 3), 0);
        issue(r_type(F3_ADD_SUB, 1'b0, 6, 5, 5), 0);
        // x5 at distance two, x6 at distance one
        issue(r_type(F3_ADD_SUB, 1'b1, 7, 5, 6), 0);
        issue(r_type(F3_XOR, 1'b0, 8, 7, 6), 0);
        issue(i_type(F3_ADD_SUB, 9, 0, 100), 0);
        issue(i_type(F3_ADD_SUB, 10, 0, 1), 0);
        issue(r_type(F3_SLL, 1'b0, 11, 9, 10), 0);
        issue(r_type(F3_OR, 1'b0, 11, 11, 11), 0);
        issue(u_type(12, 'h12345), 0);
        issue(i_type(F3_XOR, 13, 12, -1), 0);
        issue(r_type(F3_ADD_SUB, 1'b0, 14, 12, 13), 0);
        finish_test("forwarding");
    endtask

    task automatic check_bubbles();
        issue(r_type(F3_ADD_SUB, 1'b0, 0, 1, 2), 0);
        issue(i_type(F3_ADD_SUB, 0, 1, 55), 0);
        issue(u_type(0, 'hFFFFF), 0);
        issue(r_type(F3_ADD_SUB, 1'b0, 15, 0, 0), 0);
        // lw, jal, auipc, ecall and mul are outside the kept set
        issue(32'h0000_2083, 0);
        issue(32'h0000_00EF, 0);
        issue(32'h0000_1097, 0);
        issue(32'h0000_0073, 0);
        issue(32'h0220_81B3, 0);
        issue(i_type(F3_SLL, 3, 1, 'h404), 0);
        issue(r_type(F3_ADD_SUB, 1'b0, 16, 1, 0), 0);
        issue(i_type(F3_ADD_SUB, 17, 0, -5), 0);
        finish_test("bubbles and x0");
    endtask

    task automatic check_random_stream(input int count);
        for (int i = 0; i < count; i++) begin
            issue(rand_inst(), 0);
        end
        finish_test("random stream");
    endtask

    // Each writeback is matched against the oldest expected entry
    initial begin : compare_wb
        rv_reg_idx_t e_rd;
        rv_word_t    e_data;
        int          e_cycle;
        forever begin
            @(negedge clk);
            if (!rst_i && wb_valid_o) begin
                checks++;
                assert (exp_rd_q.size() != 0) else begin
                    errors++;
                    $display("unexpected writeback at %0t to x%0d", $time, wb_rd_o);
                end
                if (exp_rd_q.size() != 0) begin
                    e_rd    = exp_rd_q.pop_front();
                    e_data  = exp_data_q.pop_front();
                    e_cycle = exp_cycle_q.pop_front();
                    checks += 3;
                    assert (wb_rd_o == e_rd) else begin
                        errors++;
                        $display("mismatch at %0t: wb_rd_o got %0d expected %0d",
                                 $time, wb_rd_o, e_rd);
                    end
                    assert (wb_data_o == e_data) else begin
                        errors++;
                        $display("mismatch at %0t: wb_data_o got %h expected %h",
                                 $time, wb_data_o, e_data);
                    end
                    assert (cycle - e_cycle == LATENCY) else begin
                        errors++;
                        $display("mismatch at %0t: wb_valid_o latency got %0d expected %0d",
                                 $time, cycle - e_cycle, LATENCY);
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(34440));
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        check_after_reset();
        check_each_op();
        check_forwarding();
        check_bubbles();
        check_random_stream(500);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_alu.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_int_core.sv
tb_int_core.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line
verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module tb_int_core -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
